//--- common/mr_defs.svh
// Geometry of the 1R2W memory.
// Each row holds 4 virtual banks spread over 6 single-port physical banks.

`ifndef MR_DEFS_SVH
`define MR_DEFS_SVH

// Data word width.
`define MR_WIDTH 16

// Rows per bank and virtual banks per row.
`define MR_NUM_ROW 16
`define MR_NUM_VBANK 4

// Two spare physical banks let two writes move away from a busy bank.
`define MR_NUM_PBANK (`MR_NUM_VBANK + 2)

// Index widths.
`define MR_ROW_BITS 4
`define MR_VBANK_BITS 2
`define MR_PBANK_BITS 3

`endif

//--- common/mr_geom_pkg.sv
// Geometry types of the 1R2W memory.
// Covers data words, row and bank indices, addresses and map rows.

`include "mr_defs.svh"

package mr_geom_pkg;

  typedef logic [`MR_WIDTH-1:0] data_t;        // One data word.

  typedef logic [`MR_ROW_BITS-1:0] row_t;      // Row inside a bank.

  typedef logic [`MR_VBANK_BITS-1:0] vbank_t;  // Virtual bank of a row.

  typedef logic [`MR_PBANK_BITS-1:0] pbank_t;  // Physical bank index.

  // Word address with the row in the high bits.
  typedef struct packed {
    row_t   row;
    vbank_t vbank;
  } addr_t;

  // Physical bank of every virtual bank in one row.
  typedef pbank_t [`MR_NUM_VBANK-1:0] map_row_t;

endpackage

//--- common/mr_cmd_pkg.sv
// Request and command types of the 1R2W memory.
// Covers the port strobes, the bank commands and the map table updates.

package mr_cmd_pkg;

  import mr_geom_pkg::*;

  // Read port request.
  typedef struct packed {
    logic  read;
    addr_t addr;
  } rd_req_t;

  // Write port request.
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
  } wr_req_t;

  // Operation for one single-port bank.
  typedef enum logic [1:0] {
    BANK_IDLE  = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2
  } bank_op_e;

  typedef struct packed {
    bank_op_e op;
    row_t     row;
    data_t    data;   // Only used by writes.
  } bank_cmd_t;

  // Moves one virtual bank of a row to another physical bank.
  typedef struct packed {
    logic   vld;
    row_t   row;
    vbank_t vbank;
    pbank_t pbank;
  } map_upd_t;

endpackage

//--- mr_core/mr_map_table.sv
// Virtual to physical bank map of the 1R2W memory.
// One flop row per memory row, three lookups and two updates per cycle.

`timescale 1ns/1ps

`include "mr_defs.svh"

module mr_map_table
  import mr_geom_pkg::*;
  import mr_cmd_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  row_t     look_row [3],
  output map_row_t look_map [3],
  input  map_upd_t upd [2]
);

  map_row_t map_q [`MR_NUM_ROW];  // Current mapping of each row.

  // Lookups see the table as it stands before this cycle's updates.
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      look_map[i] = map_q[look_row[i]];  // Read, port 0 and port 1 rows.
    end
  end

  // Both updates may hit one row but never one virtual bank,
  // so the two writes into a row never overlap.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `MR_NUM_ROW; r++) begin
        for (int v = 0; v < `MR_NUM_VBANK; v++) begin
          map_q[r][v] <= pbank_t'(v);  // Identity mapping.
        end
      end
    end else begin
      for (int u = 0; u < 2; u++) begin
        if (upd[u].vld) begin
          map_q[upd[u].row][upd[u].vbank] <= upd[u].pbank;
        end
      end
    end
  end

endmodule

//--- mr_core/mr_bank_alloc.sv
// Bank allocator of the 1R2W memory.
// Gives the read and both writes separate physical banks and moves writes as needed.

`timescale 1ns/1ps

`include "mr_defs.svh"

module mr_bank_alloc
  import mr_geom_pkg::*;
  import mr_cmd_pkg::*;
(
  input  rd_req_t   rd_req,
  input  wr_req_t   wr_req [2],
  output row_t      look_row [3],
  input  map_row_t  look_map [3],
  output map_upd_t  upd [2],
  output bank_cmd_t bank_cmd [`MR_NUM_PBANK],
  output pbank_t    rd_pbank
);

  logic [1:0] wr_act;     // Write ports that really write this cycle.
  pbank_t     cur_pb [2]; // Bank each write's word sits in now.
  pbank_t     free0 [2];  // Lowest unused bank of the write row.
  pbank_t     free1 [2];  // Second unused bank of the write row.
  pbank_t     new_pb [2]; // Bank each write goes to.

  // Returns the lowest (sel low) or second lowest (sel high) bank not used in a row.
  function automatic pbank_t free_bank(input map_row_t m, input logic sel);
    logic        used;
    int unsigned cnt;
    pbank_t      res;
    cnt = 0;
    res = '0;
    for (int b = 0; b < `MR_NUM_PBANK; b++) begin
      used = 1'b0;
      for (int v = 0; v < `MR_NUM_VBANK; v++) begin
        if (m[v] == pbank_t'(b)) used = 1'b1;
      end
      if (!used) begin
        if (cnt == int'(sel)) res = pbank_t'(b);
        cnt++;
      end
    end
    return res;
  endfunction

  // Keeps the current bank if allowed, else the lowest allowed spare.
  function automatic pbank_t pick(input pbank_t cur, input pbank_t f0, input pbank_t f1,
                                  input logic ex_a_en, input pbank_t ex_a,
                                  input logic ex_b_en, input pbank_t ex_b);
    logic cur_bad;
    logic f0_bad;
    cur_bad = (ex_a_en && cur == ex_a) || (ex_b_en && cur == ex_b);
    f0_bad  = (ex_a_en && f0 == ex_a) || (ex_b_en && f0 == ex_b);
    if (!cur_bad) return cur;
    if (!f0_bad) return f0;
    return f1;
  endfunction

  assign look_row[0] = rd_req.addr.row;
  assign look_row[1] = wr_req[0].addr.row;
  assign look_row[2] = wr_req[1].addr.row;

  assign rd_pbank = look_map[0][rd_req.addr.vbank];

  // Port 1 wins when both ports write one address.
  assign wr_act[0] = wr_req[0].write &&
                     !(wr_req[1].write && wr_req[1].addr == wr_req[0].addr);
  assign wr_act[1] = wr_req[1].write;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      cur_pb[p] = look_map[p+1][wr_req[p].addr.vbank];
      free0[p]  = free_bank(look_map[p+1], 1'b0);
      free1[p]  = free_bank(look_map[p+1], 1'b1);
    end
    new_pb[0] = pick(cur_pb[0], free0[0], free1[0], rd_req.read, rd_pbank, 1'b0, '0);
    new_pb[1] = pick(cur_pb[1], free0[1], free1[1], rd_req.read, rd_pbank,
                     wr_act[0], new_pb[0]);
  end

  // A moved write records its new bank in the map.
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      upd[p].vld   = wr_act[p] && (new_pb[p] != cur_pb[p]);
      upd[p].row   = wr_req[p].addr.row;
      upd[p].vbank = wr_req[p].addr.vbank;
      upd[p].pbank = new_pb[p];
    end
  end

  // Banks chosen above are all distinct, so the priority never drops an operation.
  always_comb begin
    for (int b = 0; b < `MR_NUM_PBANK; b++) begin
      bank_cmd[b] = '{op: BANK_IDLE, row: '0, data: '0};
      if (wr_act[1] && new_pb[1] == pbank_t'(b)) begin
        bank_cmd[b] = '{op: BANK_WRITE, row: wr_req[1].addr.row, data: wr_req[1].data};
      end else if (wr_act[0] && new_pb[0] == pbank_t'(b)) begin
        bank_cmd[b] = '{op: BANK_WRITE, row: wr_req[0].addr.row, data: wr_req[0].data};
      end else if (rd_req.read && rd_pbank == pbank_t'(b)) begin
        bank_cmd[b] = '{op: BANK_READ, row: rd_req.addr.row, data: '0};
      end
    end
  end

endmodule

//--- mr_core/mr_bank.sv
// Single-port memory bank.
// One read or one write per cycle, with registered read data.

`timescale 1ns/1ps

`include "mr_defs.svh"

module mr_bank
  import mr_geom_pkg::*;
  import mr_cmd_pkg::*;
(
  input  logic      clk,
  input  bank_cmd_t cmd,
  output data_t     rdata
);

  data_t mem [`MR_NUM_ROW];  // Storage array.

  always_ff @(posedge clk) begin
    case (cmd.op)
      BANK_WRITE: mem[cmd.row] <= cmd.data;
      BANK_READ:  rdata <= mem[cmd.row];  // Held until the next read.
      default: ;
    endcase
  end

endmodule

//--- hw/mr_1r2w_top.sv
// Top of the 1R2W memory.
// Joins the bank allocator and map table to six single-port banks.

`timescale 1ns/1ps

`include "mr_defs.svh"

module mr_1r2w_top
  import mr_geom_pkg::*;
  import mr_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  rd_req_t rd_req,
  input  wr_req_t wr_req [2],
  output logic    rd_vld,
  output data_t   rd_dout
);

  row_t      look_row [3];
  map_row_t  look_map [3];
  map_upd_t  upd [2];
  bank_cmd_t bank_cmd [`MR_NUM_PBANK];
  data_t     bank_rdata [`MR_NUM_PBANK];
  pbank_t    rd_pbank;
  pbank_t    rd_pbank_q;  // Bank whose data comes out this cycle.
  logic      rd_vld_q;    // First stage of the read valid.

  mr_map_table i_map_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .look_row (look_row),
    .look_map (look_map),
    .upd      (upd)
  );

  mr_bank_alloc i_bank_alloc (
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .look_row (look_row),
    .look_map (look_map),
    .upd      (upd),
    .bank_cmd (bank_cmd),
    .rd_pbank (rd_pbank)
  );

  for (genvar b = 0; b < `MR_NUM_PBANK; b++) begin : g_bank
    mr_bank i_bank (
      .clk   (clk),
      .cmd   (bank_cmd[b]),
      .rdata (bank_rdata[b])
    );
  end

  // Read valid follows the bank read by two cycles.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
      rd_vld   <= 1'b0;
    end else begin
      rd_vld_q <= rd_req.read;
      rd_vld   <= rd_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    rd_pbank_q <= rd_pbank;  // Lines up with the bank's read data.
    if (rd_vld_q) begin
      rd_dout <= bank_rdata[rd_pbank_q];
    end
  end

endmodule

//--- sim/mr_tb.sv
// Testbench for the 1R2W memory.
// Random and directed traffic checked against a word-level model.

`timescale 1ns/1ps

`include "mr_defs.svh"

module mr_tb
  import mr_geom_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 32'h3bc0;
  localparam int NUM_WORDS  = `MR_NUM_ROW * `MR_NUM_VBANK;
  localparam int N_PAIR     = 8;     // Iterations of each directed case.
  localparam int N_RAND     = 2000;  // Cycles of random traffic.
  localparam int N_DRAIN    = 4;     // Idle cycles after each phase.
  localparam int OP_COUNT   = 2 * NUM_WORDS + 7 * N_PAIR + N_RAND + 5 * N_DRAIN;
  localparam int TIMEOUT_NS = (OP_COUNT + 40) * CLK_PERIOD;

  logic                clk;
  logic                rst_n;
  mr_cmd_pkg::rd_req_t rd_req;
  mr_cmd_pkg::wr_req_t wr_req [2];
  logic                rd_vld;
  data_t               rd_dout;

  data_t model_mem [NUM_WORDS];  // Expected contents.
  logic  model_vld [NUM_WORDS];  // Word has been written.
  int    due_q [$];              // Cycle in which each read must come out.
  data_t data_q [$];
  logic  chk_q [$];              // Low for reads of unwritten words.
  int    cyc = 0;

  mr_1r2w_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;  // Counts rising edges.

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // Drives one cycle of requests and updates the model in the accept order.
  task automatic do_cycle(input logic rd_en, input int rd_a,
                          input logic w0_en, input int w0_a, input data_t w0_d,
                          input logic w1_en, input int w1_a, input data_t w1_d);
    @(posedge clk);
    #1;
    rd_req.read      = rd_en;
    rd_req.addr      = addr_t'(rd_a[5:0]);
    wr_req[0].write  = w0_en;
    wr_req[0].addr   = addr_t'(w0_a[5:0]);
    wr_req[0].data   = w0_d;
    wr_req[1].write  = w1_en;
    wr_req[1].addr   = addr_t'(w1_a[5:0]);
    wr_req[1].data   = w1_d;
    if (rd_en) begin
      due_q.push_back(cyc + 2);  // Accepted at the next edge, out one edge later.
      data_q.push_back(model_mem[rd_a]);
      chk_q.push_back(model_vld[rd_a]);
    end
    if (w0_en) begin
      model_mem[w0_a] = w0_d;
      model_vld[w0_a] = 1'b1;
    end
    if (w1_en) begin
      model_mem[w1_a] = w1_d;  // Port 1 lands last and wins.
      model_vld[w1_a] = 1'b1;
    end
  endtask

  task automatic write_word(input int port, input int a, input data_t d);
    if (port == 0) begin
      do_cycle(1'b0, 0, 1'b1, a, d, 1'b0, 0, '0);
    end else begin
      do_cycle(1'b0, 0, 1'b0, 0, '0, 1'b1, a, d);
    end
  endtask

  task automatic read_word(input int a);
    do_cycle(1'b1, a, 1'b0, 0, '0, 1'b0, 0, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) do_cycle(1'b0, 0, 1'b0, 0, '0, 1'b0, 0, '0);
  endtask

  // Read responses are compared mid-cycle, away from the driving edge.
  always @(negedge clk) begin
    if (rst_n) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        check("rd_vld", 32'(rd_vld), 1);
        if (chk_q[0]) check("rd_dout", 32'(rd_dout), 32'(data_q[0]));
        void'(due_q.pop_front());
        void'(data_q.pop_front());
        void'(chk_q.pop_front());
      end else begin
        check("rd_vld", 32'(rd_vld), 0);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    stop_with_failure();
  end

  initial begin
    int    r0;
    int    r1;
    int    r2;
    int    vb;
    int    a;
    data_t d0;
    data_t d1;
    int    pool [8];
    void'($urandom(SEED));
    clk    = 1'b0;
    rst_n  = 1'b0;
    rd_req = '0;
    wr_req[0] = '0;
    wr_req[1] = '0;
    for (int i = 0; i < NUM_WORDS; i++) model_vld[i] = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Fill every word, alternating ports, then read all back.
    for (int i = 0; i < NUM_WORDS; i++) write_word(i % 2, i, data_t'($urandom));
    for (int i = 0; i < NUM_WORDS; i++) read_word(i);
    idle(N_DRAIN);

    // Two writes and a read on three rows of one virtual bank.
    for (int i = 0; i < N_PAIR; i++) begin
      vb = $urandom % `MR_NUM_VBANK;
      r0 = $urandom % `MR_NUM_ROW;
      r1 = (r0 + 1 + $urandom % 7) % `MR_NUM_ROW;
      r2 = (r0 + 8 + $urandom % 7) % `MR_NUM_ROW;
      d0 = data_t'($urandom);
      d1 = data_t'($urandom);
      do_cycle(1'b1, r2 * `MR_NUM_VBANK + vb, 1'b1, r0 * `MR_NUM_VBANK + vb, d0,
               1'b1, r1 * `MR_NUM_VBANK + vb, d1);
      read_word(r0 * `MR_NUM_VBANK + vb);
      read_word(r1 * `MR_NUM_VBANK + vb);
    end
    idle(N_DRAIN);

    // Both ports on one address.
    for (int i = 0; i < N_PAIR; i++) begin
      a = $urandom % NUM_WORDS;
      do_cycle(1'b0, 0, 1'b1, a, data_t'($urandom), 1'b1, a, data_t'($urandom));
      read_word(a);
    end
    idle(N_DRAIN);

    // Read and write of one address in one cycle.
    for (int i = 0; i < N_PAIR; i++) begin
      a  = $urandom % NUM_WORDS;
      d0 = data_t'($urandom);
      if (i % 2 == 0) do_cycle(1'b1, a, 1'b1, a, d0, 1'b0, 0, '0);
      else do_cycle(1'b1, a, 1'b0, 0, '0, 1'b1, a, d0);
      read_word(a);
    end
    idle(N_DRAIN);

    // Random traffic on a small pool of two virtual banks.
    for (int i = 0; i < 8; i++) begin
      pool[i] = ($urandom % `MR_NUM_ROW) * `MR_NUM_VBANK + ($urandom % 2);
    end
    for (int i = 0; i < N_RAND; i++) begin
      do_cycle($urandom % 4 != 0, pool[$urandom % 8],
               $urandom % 3 != 0, pool[$urandom % 8], data_t'($urandom),
               $urandom % 3 != 0, pool[$urandom % 8], data_t'($urandom));
    end
    idle(N_DRAIN);

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- mr_1r2w.f
+incdir+common
common/mr_geom_pkg.sv
common/mr_cmd_pkg.sv
mr_core/mr_map_table.sv
mr_core/mr_bank_alloc.sv
mr_core/mr_bank.sv
hw/mr_1r2w_top.sv
sim/mr_tb.sv

//--- Makefile
# Verilator build and run of the 1R2W memory testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = mr_tb
FILELIST  = mr_1r2w.f

PASS_MSG  = Done: no errors

.PHONY: sim clean

# Builds, runs and passes only when the pass message is printed.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
